/* design/bp_pkg.sv */
`default_nettype none

package bp_pkg;

  // word address and instruction width
  localparam int addr_w = 32;

  // opcode field of the fetched instruction, bits [6:0]
  typedef enum logic [6:0] {
    op_other  = 7'b0000000, // anything that is not a control transfer
    op_jal    = 7'b1101111,
    op_jalr   = 7'b1100111,
    op_branch = 7'b1100011
  } opcode_e;

  // two-bit saturating counter, upper bit predicts taken
  typedef enum logic [1:0] {
    strong_nt = 2'd0,
    weak_nt   = 2'd1,
    weak_t    = 2'd2,
    strong_t  = 2'd3
  } ctr_e;

  localparam ctr_e ctr_reset = weak_nt;

endpackage

`default_nettype wire

/* design/branch_decode.sv */
`timescale 1ns/1ns
`default_nettype none

module branch_decode (
  input  wire [bp_pkg::addr_w-1:0] fetch_instr,
  output logic                     is_ctrl
);

  import bp_pkg::*;

  opcode_e opcode;
  opcode_e kind;

  always_comb begin
    opcode = opcode_e'(fetch_instr[6:0]);
    case (opcode)
      op_jal, op_jalr, op_branch: kind = opcode;
      default:                    kind = op_other; // alu, load, store, system
    endcase
    is_ctrl = (kind != op_other);
  end

endmodule

`default_nettype wire

/* design/predict_tables.sv */
`timescale 1ns/1ns
`default_nettype none

module predict_tables #(
  parameter int idx_w  = 8,
  parameter int hist_w = 2
) (
  input  wire                             clk,
  input  wire                             rstn,

  // fetch read port
  input  wire [idx_w-1:0]                 fetch_idx,
  input  wire [hist_w-1:0]                fetch_hist,
  output bp_pkg::ctr_e                    rd_ctr,
  output logic [bp_pkg::addr_w-idx_w-1:0] rd_tag,
  output logic [bp_pkg::addr_w-1:0]       rd_target,

  // resolve read port
  input  wire [idx_w-1:0]                 res_idx,
  input  wire [hist_w-1:0]                res_hist,
  output bp_pkg::ctr_e                    res_ctr,

  // write port
  input  wire                             wr_en,
  input  wire [idx_w-1:0]                 wr_idx,
  input  wire [hist_w-1:0]                wr_hist,
  input  wire bp_pkg::ctr_e               wr_ctr,
  input  wire                             wr_target_en,
  input  wire [bp_pkg::addr_w-idx_w-1:0]  wr_tag,
  input  wire [bp_pkg::addr_w-1:0]        wr_target
);

  import bp_pkg::*;

  localparam int tag_w   = addr_w - idx_w;
  localparam int entries = 2 ** idx_w;
  localparam int ways    = 2 ** hist_w; // one counter per history pattern

  ctr_e             pht     [entries][ways];
  logic [tag_w-1:0] tag_mem [entries];
  logic [addr_w-1:0] tgt_mem [entries];

  // both reads are combinational
  assign rd_ctr    = pht[fetch_idx][fetch_hist];
  assign rd_tag    = tag_mem[fetch_idx];
  assign rd_target = tgt_mem[fetch_idx];
  assign res_ctr   = pht[res_idx][res_hist];

  always_ff @(posedge clk) begin
    if (rstn) begin
      for (int i = 0; i < entries; i++) begin
        tag_mem[i] <= '0;
        tgt_mem[i] <= '0;
        for (int h = 0; h < ways; h++) begin
          pht[i][h] <= ctr_reset;
        end
      end
    end else begin
      if (wr_en) begin
        pht[wr_idx][wr_hist] <= wr_ctr;
      end
      if (wr_target_en) begin
        tag_mem[wr_idx] <= wr_tag;
        tgt_mem[wr_idx] <= wr_target;
      end
    end
  end

endmodule

`default_nettype wire

/* design/predict_lookup.sv */
`timescale 1ns/1ns
`default_nettype none

module predict_lookup #(
  parameter int idx_w  = 8,
  parameter int hist_w = 2
) (
  input  wire [bp_pkg::addr_w-1:0]       fetch_pc,
  input  wire                            is_ctrl,
  input  wire [hist_w-1:0]               ghist,

  output logic [idx_w-1:0]               fetch_idx,
  output logic [hist_w-1:0]              fetch_hist,
  input  wire bp_pkg::ctr_e              rd_ctr,
  input  wire [bp_pkg::addr_w-idx_w-1:0] rd_tag,
  input  wire [bp_pkg::addr_w-1:0]       rd_target,

  output logic [bp_pkg::addr_w-1:0]      pred_next_pc,
  output logic [hist_w-1:0]              pred_hist
);

  import bp_pkg::*;

  localparam int tag_w = addr_w - idx_w;

  logic [tag_w-1:0] pc_tag;
  logic             tag_hit;
  logic             pred_taken;

  assign fetch_idx  = fetch_pc[idx_w-1:0];
  assign fetch_hist = ghist;
  assign pc_tag     = fetch_pc[addr_w-1:idx_w];

  assign tag_hit    = (rd_tag == pc_tag);
  assign pred_taken = is_ctrl && rd_ctr[1] && tag_hit; // upper counter bit

  assign pred_next_pc = pred_taken ? rd_target : fetch_pc + 1'b1;
  assign pred_hist    = ghist; // returned with the branch at resolve

endmodule

`default_nettype wire

/* design/predict_update.sv */
`timescale 1ns/1ns
`default_nettype none

module predict_update #(
  parameter int idx_w  = 8,
  parameter int hist_w = 2
) (
  input  wire                             clk,
  input  wire                             rstn,

  input  wire                             resolve_valid,
  input  wire [bp_pkg::addr_w-1:0]        resolve_pc,
  input  wire [hist_w-1:0]                resolve_hist,
  input  wire [bp_pkg::addr_w-1:0]        resolve_next_pc,
  input  wire [bp_pkg::addr_w-1:0]        resolve_target,
  input  wire                             resolve_taken,

  // second table read port
  output logic [idx_w-1:0]                res_idx,
  output logic [hist_w-1:0]               res_hist,
  input  wire bp_pkg::ctr_e               res_ctr,

  // table write port
  output logic                            wr_en,
  output logic [idx_w-1:0]                wr_idx,
  output logic [hist_w-1:0]               wr_hist,
  output bp_pkg::ctr_e                    wr_ctr,
  output logic                            wr_target_en,
  output logic [bp_pkg::addr_w-idx_w-1:0] wr_tag,
  output logic [bp_pkg::addr_w-1:0]       wr_target,

  output logic [hist_w-1:0]               ghist,
  output logic                            mispredict,
  output logic [bp_pkg::addr_w-1:0]       redirect_pc,
  output logic [31:0]                     stat_total,
  output logic [31:0]                     stat_hit,
  output logic [31:0]                     stat_miss
);

  import bp_pkg::*;

  ctr_e next_ctr;
  logic hit;

  // one step toward the outcome, saturating at both ends
  always_comb begin
    case (res_ctr)
      strong_nt: next_ctr = resolve_taken ? weak_nt  : strong_nt;
      weak_nt:   next_ctr = resolve_taken ? weak_t   : strong_nt;
      weak_t:    next_ctr = resolve_taken ? strong_t : weak_nt;
      strong_t:  next_ctr = resolve_taken ? strong_t : weak_t;
      default:   next_ctr = ctr_reset;
    endcase
  end

  assign hit = (resolve_target == resolve_next_pc); // fetch already went the right way

  assign res_idx  = resolve_pc[idx_w-1:0];
  assign res_hist = resolve_hist;

  assign wr_en        = resolve_valid;
  assign wr_idx       = res_idx;
  assign wr_hist      = resolve_hist;
  assign wr_ctr       = next_ctr;
  assign wr_target_en = resolve_valid && !hit && resolve_taken;
  assign wr_tag       = resolve_pc[addr_w-1:idx_w];
  assign wr_target    = resolve_target;

  always_ff @(posedge clk) begin
    if (rstn) begin
      ghist       <= '0;
      mispredict  <= 1'b0;
      redirect_pc <= '0;
      stat_total  <= '0;
      stat_hit    <= '0;
      stat_miss   <= '0;
    end else begin
      mispredict <= resolve_valid && !hit; // single cycle pulse
      if (resolve_valid) begin
        ghist       <= hist_w'({ghist, resolve_taken});
        redirect_pc <= resolve_target;
        stat_total  <= stat_total + 32'd1;
        if (hit) begin
          stat_hit <= stat_hit + 32'd1;
        end else begin
          stat_miss <= stat_miss + 32'd1;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* design/branch_predictor.sv */
`timescale 1ns/1ns
`default_nettype none

module branch_predictor #(
  parameter int idx_w  = 8,  // 256 entries
  parameter int hist_w = 2
) (
  input  wire                        clk,
  input  wire                        rstn,

  input  wire [bp_pkg::addr_w-1:0]   fetch_pc,
  input  wire [bp_pkg::addr_w-1:0]   fetch_instr,

  input  wire                        resolve_valid,
  input  wire [bp_pkg::addr_w-1:0]   resolve_pc,
  input  wire [hist_w-1:0]           resolve_hist,
  input  wire [bp_pkg::addr_w-1:0]   resolve_next_pc,
  input  wire [bp_pkg::addr_w-1:0]   resolve_target,
  input  wire                        resolve_taken,

  output logic [bp_pkg::addr_w-1:0]  pred_next_pc,
  output logic [hist_w-1:0]          pred_hist,
  output logic                       mispredict,
  output logic [bp_pkg::addr_w-1:0]  redirect_pc,
  output logic [31:0]                stat_total,
  output logic [31:0]                stat_hit,
  output logic [31:0]                stat_miss
);

  import bp_pkg::*;

  localparam int tag_w = addr_w - idx_w;

  logic              is_ctrl;
  logic [hist_w-1:0] ghist;

  // fetch side table port
  logic [idx_w-1:0]  fetch_idx;
  logic [hist_w-1:0] fetch_hist;
  ctr_e              rd_ctr;
  logic [tag_w-1:0]  rd_tag;
  logic [addr_w-1:0] rd_target;

  // resolve side table port
  logic [idx_w-1:0]  res_idx;
  logic [hist_w-1:0] res_hist;
  ctr_e              res_ctr;
  logic              wr_en;
  logic [idx_w-1:0]  wr_idx;
  logic [hist_w-1:0] wr_hist;
  ctr_e              wr_ctr;
  logic              wr_target_en;
  logic [tag_w-1:0]  wr_tag;
  logic [addr_w-1:0] wr_target;

  branch_decode decode_i (
    .fetch_instr (fetch_instr),
    .is_ctrl     (is_ctrl)
  );

  predict_lookup #(.idx_w(idx_w), .hist_w(hist_w)) lookup_i (
    .fetch_pc     (fetch_pc),
    .is_ctrl      (is_ctrl),
    .ghist        (ghist),
    .fetch_idx    (fetch_idx),
    .fetch_hist   (fetch_hist),
    .rd_ctr       (rd_ctr),
    .rd_tag       (rd_tag),
    .rd_target    (rd_target),
    .pred_next_pc (pred_next_pc),
    .pred_hist    (pred_hist)
  );

  predict_tables #(.idx_w(idx_w), .hist_w(hist_w)) tables_i (
    .clk          (clk),
    .rstn         (rstn),
    .fetch_idx    (fetch_idx),
    .fetch_hist   (fetch_hist),
    .rd_ctr       (rd_ctr),
    .rd_tag       (rd_tag),
    .rd_target    (rd_target),
    .res_idx      (res_idx),
    .res_hist     (res_hist),
    .res_ctr      (res_ctr),
    .wr_en        (wr_en),
    .wr_idx       (wr_idx),
    .wr_hist      (wr_hist),
    .wr_ctr       (wr_ctr),
    .wr_target_en (wr_target_en),
    .wr_tag       (wr_tag),
    .wr_target    (wr_target)
  );

  predict_update #(.idx_w(idx_w), .hist_w(hist_w)) update_i (
    .clk             (clk),
    .rstn            (rstn),
    .resolve_valid   (resolve_valid),
    .resolve_pc      (resolve_pc),
    .resolve_hist    (resolve_hist),
    .resolve_next_pc (resolve_next_pc),
    .resolve_target  (resolve_target),
    .resolve_taken   (resolve_taken),
    .res_idx         (res_idx),
    .res_hist        (res_hist),
    .res_ctr         (res_ctr),
    .wr_en           (wr_en),
    .wr_idx          (wr_idx),
    .wr_hist         (wr_hist),
    .wr_ctr          (wr_ctr),
    .wr_target_en    (wr_target_en),
    .wr_tag          (wr_tag),
    .wr_target       (wr_target),
    .ghist           (ghist),
    .mispredict      (mispredict),
    .redirect_pc     (redirect_pc),
    .stat_total      (stat_total),
    .stat_hit        (stat_hit),
    .stat_miss       (stat_miss)
  );

endmodule

`default_nettype wire

/* include/tb_vectors.svh */
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// add_stim columns are fetch_pc, fetch_instr and the resolve valid, pc, hist,
// next_pc, target and taken
// add_expect columns are pred_next_pc and pred_hist, then one cycle later
// mispredict, redirect_pc, total, hit and miss

localparam logic [31:0] rand_alu = 32'h0000_0000; // replaced by a random non-branch word
localparam logic [31:0] beq_op   = 32'h00b5_0463;
localparam logic [31:0] jal_op   = 32'h0000_006f;

task automatic load_table();
  // plain instruction and untrained branch right after reset
  add_stim(32'h020, rand_alu, 1'b0, 32'h000, 2'd0, 32'h000, 32'h000, 1'b0);
  add_expect(32'h021, 2'd0, 1'b0, 32'h000, 0, 0, 0);
  add_stim(32'h100, beq_op, 1'b0, 32'h000, 2'd0, 32'h000, 32'h000, 1'b0);
  add_expect(32'h101, 2'd0, 1'b0, 32'h000, 0, 0, 0);
  // taken branch fetched as pc+1 moves the history from 00 to 01
  add_stim(32'h100, beq_op, 1'b1, 32'h100, 2'd0, 32'h101, 32'h140, 1'b1);
  add_expect(32'h101, 2'd0, 1'b1, 32'h140, 1, 0, 1);
  add_stim(32'h100, beq_op, 1'b0, 32'h000, 2'd0, 32'h000, 32'h000, 1'b0);
  add_expect(32'h101, 2'd1, 1'b0, 32'h140, 1, 0, 1);
  // train the counters at histories 01 and 11
  add_stim(32'h100, beq_op, 1'b1, 32'h100, 2'd1, 32'h101, 32'h140, 1'b1);
  add_expect(32'h101, 2'd1, 1'b1, 32'h140, 2, 0, 2);
  add_stim(32'h100, beq_op, 1'b1, 32'h100, 2'd3, 32'h101, 32'h140, 1'b1);
  add_expect(32'h101, 2'd3, 1'b1, 32'h140, 3, 0, 3);
  add_stim(32'h100, beq_op, 1'b0, 32'h000, 2'd0, 32'h000, 32'h000, 1'b0);
  add_expect(32'h140, 2'd3, 1'b0, 32'h140, 3, 0, 3);
  // correct prediction counts as a hit
  add_stim(32'h100, beq_op, 1'b1, 32'h100, 2'd3, 32'h140, 32'h140, 1'b1);
  add_expect(32'h140, 2'd3, 1'b0, 32'h140, 4, 1, 3);
  // same index with another tag
  add_stim(32'h200, jal_op, 1'b0, 32'h000, 2'd0, 32'h000, 32'h000, 1'b0);
  add_expect(32'h201, 2'd3, 1'b0, 32'h140, 4, 1, 3);
  // not-taken resolves walk the 11 counter down to strong_nt
  add_stim(32'h100, beq_op, 1'b1, 32'h100, 2'd3, 32'h140, 32'h101, 1'b0);
  add_expect(32'h140, 2'd3, 1'b1, 32'h101, 5, 1, 4);
  add_stim(32'h100, beq_op, 1'b1, 32'h100, 2'd3, 32'h101, 32'h101, 1'b0);
  add_expect(32'h101, 2'd2, 1'b0, 32'h101, 6, 2, 4);
  add_stim(32'h100, beq_op, 1'b1, 32'h100, 2'd3, 32'h101, 32'h101, 1'b0);
  add_expect(32'h140, 2'd0, 1'b0, 32'h101, 7, 3, 4);
  add_stim(32'h100, beq_op, 1'b1, 32'h100, 2'd3, 32'h101, 32'h101, 1'b0);
  add_expect(32'h140, 2'd0, 1'b0, 32'h101, 8, 4, 4);
  // a second branch brings the history back to 11
  // plain words fetched at the trained entry still go to pc+1
  add_stim(32'h100, rand_alu, 1'b1, 32'h180, 2'd0, 32'h181, 32'h181, 1'b1);
  add_expect(32'h101, 2'd0, 1'b0, 32'h181, 9, 5, 4);
  add_stim(32'h100, rand_alu, 1'b1, 32'h180, 2'd1, 32'h181, 32'h181, 1'b1);
  add_expect(32'h101, 2'd1, 1'b0, 32'h181, 10, 6, 4);
  add_stim(32'h100, beq_op, 1'b0, 32'h000, 2'd0, 32'h000, 32'h000, 1'b0);
  add_expect(32'h101, 2'd3, 1'b0, 32'h181, 10, 6, 4);
  // back at history 00 the old target is still in place
  add_stim(32'h100, beq_op, 1'b1, 32'h180, 2'd3, 32'h181, 32'h181, 1'b0);
  add_expect(32'h101, 2'd3, 1'b0, 32'h181, 11, 7, 4);
  add_stim(32'h100, beq_op, 1'b1, 32'h180, 2'd2, 32'h181, 32'h181, 1'b0);
  add_expect(32'h101, 2'd2, 1'b0, 32'h181, 12, 8, 4);
  add_stim(32'h100, beq_op, 1'b0, 32'h000, 2'd0, 32'h000, 32'h000, 1'b0);
  add_expect(32'h140, 2'd0, 1'b0, 32'h181, 12, 8, 4);
endtask

`endif

/* verif/tb_branch_predictor.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_branch_predictor;

  localparam int hist_w     = 2;
  localparam int max_rows   = 32;
  localparam int rst_cycles = 10;

  logic              clk;
  logic              rstn;
  logic [31:0]       fetch_pc;
  logic [31:0]       fetch_instr;
  logic              resolve_valid;
  logic [31:0]       resolve_pc;
  logic [hist_w-1:0] resolve_hist;
  logic [31:0]       resolve_next_pc;
  logic [31:0]       resolve_target;
  logic              resolve_taken;
  logic [31:0]       pred_next_pc;
  logic [hist_w-1:0] pred_hist;
  logic              mispredict;
  logic [31:0]       redirect_pc;
  logic [31:0]       stat_total;
  logic [31:0]       stat_hit;
  logic [31:0]       stat_miss;

  // stimulus columns
  logic [31:0]       st_pc     [max_rows];
  logic [31:0]       st_instr  [max_rows];
  logic              st_valid  [max_rows];
  logic [31:0]       st_rpc    [max_rows];
  logic [hist_w-1:0] st_rhist  [max_rows];
  logic [31:0]       st_rnext  [max_rows];
  logic [31:0]       st_rtgt   [max_rows];
  logic              st_rtaken [max_rows];
  // expected columns
  logic [31:0]       ex_pred   [max_rows];
  logic [hist_w-1:0] ex_hist   [max_rows];
  logic              ex_misp   [max_rows];
  logic [31:0]       ex_redir  [max_rows];
  logic [31:0]       ex_total  [max_rows];
  logic [31:0]       ex_hit    [max_rows];
  logic [31:0]       ex_miss   [max_rows];
  int                row_base  [max_rows]; // error count when the row started

  int     n_rows = 0;
  int     errors = 0;
  int     checks = 0;
  int     cycles = 0;
  int     limit  = 0;
  integer seed;

  branch_predictor #(.idx_w(8), .hist_w(hist_w)) dut_i (
    .clk             (clk),
    .rstn            (rstn),
    .fetch_pc        (fetch_pc),
    .fetch_instr     (fetch_instr),
    .resolve_valid   (resolve_valid),
    .resolve_pc      (resolve_pc),
    .resolve_hist    (resolve_hist),
    .resolve_next_pc (resolve_next_pc),
    .resolve_target  (resolve_target),
    .resolve_taken   (resolve_taken),
    .pred_next_pc    (pred_next_pc),
    .pred_hist       (pred_hist),
    .mispredict      (mispredict),
    .redirect_pc     (redirect_pc),
    .stat_total      (stat_total),
    .stat_hit        (stat_hit),
    .stat_miss       (stat_miss)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles++;
    if (limit > 0 && cycles > limit) begin
      $display("timeout: run went past %0d cycles", limit);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  task automatic add_stim(input logic [31:0] pc, input logic [31:0] instr, input logic valid,
                          input logic [31:0] rpc, input logic [hist_w-1:0] rhist,
                          input logic [31:0] rnext, input logic [31:0] rtgt,
                          input logic rtaken);
    st_pc[n_rows]     = pc;
    st_instr[n_rows]  = instr;
    st_valid[n_rows]  = valid;
    st_rpc[n_rows]    = rpc;
    st_rhist[n_rows]  = rhist;
    st_rnext[n_rows]  = rnext;
    st_rtgt[n_rows]   = rtgt;
    st_rtaken[n_rows] = rtaken;
  endtask

  task automatic add_expect(input logic [31:0] pred, input logic [hist_w-1:0] hist,
                            input logic misp, input logic [31:0] redir,
                            input logic [31:0] total, input logic [31:0] hit,
                            input logic [31:0] miss);
    ex_pred[n_rows]  = pred;
    ex_hist[n_rows]  = hist;
    ex_misp[n_rows]  = misp;
    ex_redir[n_rows] = redir;
    ex_total[n_rows] = total;
    ex_hit[n_rows]   = hit;
    ex_miss[n_rows]  = miss;
    n_rows++; // row complete
  endtask

  `include "tb_vectors.svh"

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] want);
    checks++;
    assert (got === want) else begin
      $display("ERROR %s expected %h got %h", name, want, got);
      errors++;
    end
  endtask

  task automatic idle_inputs();
    resolve_valid   = 1'b0;
    resolve_pc      = '0;
    resolve_hist    = '0;
    resolve_next_pc = '0;
    resolve_target  = '0;
    resolve_taken   = 1'b0;
  endtask

  task automatic drive_row(input int i);
    row_base[i]     = errors;
    fetch_pc        = st_pc[i];
    fetch_instr     = st_instr[i];
    resolve_valid   = st_valid[i];
    resolve_pc      = st_rpc[i];
    resolve_hist    = st_rhist[i];
    resolve_next_pc = st_rnext[i];
    resolve_target  = st_rtgt[i];
    resolve_taken   = st_rtaken[i];
  endtask

  // combinational fetch side, same cycle
  task automatic check_fetch(input int i);
    compare("pred_next_pc", pred_next_pc, ex_pred[i]);
    compare("pred_hist", 32'(pred_hist), 32'(ex_hist[i]));
  endtask

  // registered side, one cycle after the row
  task automatic check_resolve(input int i);
    compare("mispredict", 32'(mispredict), 32'(ex_misp[i]));
    compare("redirect_pc", redirect_pc, ex_redir[i]);
    compare("stat_total", stat_total, ex_total[i]);
    compare("stat_hit", stat_hit, ex_hit[i]);
    compare("stat_miss", stat_miss, ex_miss[i]);
    $display("row %0d: %s", i, (errors == row_base[i]) ? "ok" : "mismatch");
  endtask

  initial begin
    logic [31:0] r;
    seed        = 32'hcb62ccec;
    rstn        = 1'b1;
    fetch_pc    = '0;
    fetch_instr = '0;
    idle_inputs();
    load_table();
    limit = n_rows * 2 + rst_cycles + 20;
    for (int i = 0; i < n_rows; i++) begin
      if (st_instr[i] == rand_alu) begin
        r = $random(seed);
        if (r[6:0] == 7'b1101111 || r[6:0] == 7'b1100111 || r[6:0] == 7'b1100011) begin
          r[6] = 1'b0; // moves jal, jalr and branch onto non-control opcodes
        end
        st_instr[i] = r;
      end
    end
    repeat (rst_cycles) @(posedge clk);
    #2;
    rstn = 1'b0;
    for (int i = 0; i < n_rows; i++) begin
      @(posedge clk);
      #2;
      if (i > 0) begin
        check_resolve(i - 1);
      end
      drive_row(i);
      #28;
      check_fetch(i);
    end
    @(posedge clk);
    #2;
    check_resolve(n_rows - 1);
    idle_inputs();
    $display("summary: %0d rows, %0d checks, %0d errors", n_rows, checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* filelist.f */
design/bp_pkg.sv
design/branch_decode.sv
design/predict_tables.sv
design/predict_lookup.sv
design/predict_update.sv
design/branch_predictor.sv
+incdir+include
verif/tb_branch_predictor.sv

/* run.sh */
#!/bin/sh
# build and run the branch predictor testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_branch_predictor \
  -f filelist.f \
  -o tb_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "TESTBENCH PASSED" sim.log; then
  exit 0
else
  echo "pass message not found in sim.log"
  exit 1
fi
